// File: src/dc_slice_pkg.sv
package dc_slice_pkg;

   ////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////

   // Byte address from the master
   localparam int unsigned ADDR_WIDTH = 32;
   // One data word
   localparam int unsigned DATA_WIDTH = 32;
   // One enable per byte lane
   localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;
   // Transaction tag returned with the response
   localparam int unsigned ID_WIDTH = 4;

   // Entries per token ring
   localparam int unsigned BUFFER_DEPTH = 4;

   // Memory bank geometry
   localparam int unsigned BANK_WORDS = 64;
   // Word index taken from address bits 7 down to 2
   localparam int unsigned BANK_AW = $clog2(BANK_WORDS);

   ////////////////////////////////////////
   // Payloads
   ////////////////////////////////////////

   // Request crossing into the bank domain
   // wen high marks a read
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] addr;
      logic                  wen;
      logic [DATA_WIDTH-1:0] wdata;
      logic [BE_WIDTH-1:0]   be;
      logic [ID_WIDTH-1:0]   id;
   } dc_req_t;

   // Response crossing back to the master domain
   typedef struct packed {
      logic [DATA_WIDTH-1:0] rdata;
      logic [ID_WIDTH-1:0]   id;
   } dc_resp_t;

endpackage

// File: src/dc_token_fifo_din.sv
`timescale 1ns/1ps

module dc_token_fifo_din #(
   parameter type payload_t = logic
) (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,
   input  payload_t                              data_i,
   input  logic                                  valid_i,
   output logic                                  ready_o,
   output logic [dc_slice_pkg::BUFFER_DEPTH-1:0] write_token_o,
   input  logic [dc_slice_pkg::BUFFER_DEPTH-1:0] read_pointer_i,
   output payload_t                              data_async_o [dc_slice_pkg::BUFFER_DEPTH]
);

   // One-hot slot owned by the writer
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] write_token_q;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] write_token_next;
   // Remote read pointer after two flops
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] rptr_sync_q1;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] rptr_sync_q2;
   logic                                  full;
   logic                                  push;
   // Ring storage read from the other domain
   payload_t                              storage_q [dc_slice_pkg::BUFFER_DEPTH];

   // Token rotates up by one slot per write
   assign write_token_next = {write_token_q[dc_slice_pkg::BUFFER_DEPTH-2:0],
                              write_token_q[dc_slice_pkg::BUFFER_DEPTH-1]};

   // Ring full once the next slot is still owned by the reader
   assign full    = (write_token_next == rptr_sync_q2);
   assign ready_o = ~full;
   assign push    = valid_i & ready_o;

   ////////////////////////////////////////
   // Token and pointer sync
   ////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         // Writer and reader both start on slot 0
         write_token_q <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
         rptr_sync_q1  <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
         rptr_sync_q2  <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
      end else begin
         rptr_sync_q1 <= read_pointer_i;
         rptr_sync_q2 <= rptr_sync_q1;
         if (push) begin
            write_token_q <= write_token_next;
         end
      end
   end

   // Payload slots
   // Data settles here before the token reaches the reader
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < dc_slice_pkg::BUFFER_DEPTH; i++) begin
         if (push && write_token_q[i]) begin
            storage_q[i] <= data_i;
         end
      end
   end

   assign write_token_o = write_token_q;
   assign data_async_o  = storage_q;

endmodule

// File: src/dc_token_fifo_dout.sv
`timescale 1ns/1ps

module dc_token_fifo_dout #(
   parameter type payload_t = logic
) (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,
   output payload_t                              data_o,
   output logic                                  valid_o,
   input  logic                                  ready_i,
   input  logic [dc_slice_pkg::BUFFER_DEPTH-1:0] write_token_i,
   output logic [dc_slice_pkg::BUFFER_DEPTH-1:0] read_pointer_o,
   input  payload_t                              data_async_i [dc_slice_pkg::BUFFER_DEPTH]
);

   // One-hot slot the reader consumes next
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] read_ptr_q;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] read_ptr_next;
   // Remote write token after two flops
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] wtok_sync_q1;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] wtok_sync_q2;
   logic                                  empty;
   logic                                  pop;

   // Same rotation as the writer
   assign read_ptr_next = {read_ptr_q[dc_slice_pkg::BUFFER_DEPTH-2:0],
                           read_ptr_q[dc_slice_pkg::BUFFER_DEPTH-1]};

   // Empty when the writer has not moved past us
   assign empty   = (wtok_sync_q2 == read_ptr_q);
   assign valid_o = ~empty;
   assign pop     = valid_o & ready_i;

   ////////////////////////////////////////
   // Pointer and token sync
   ////////////////////////////////////////

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         // Slot 0 matches the writer reset
         read_ptr_q   <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
         wtok_sync_q1 <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
         wtok_sync_q2 <= {{(dc_slice_pkg::BUFFER_DEPTH-1){1'b0}}, 1'b1};
      end else begin
         wtok_sync_q1 <= write_token_i;
         wtok_sync_q2 <= wtok_sync_q1;
         // Hand the slot back to the writer
         if (pop) begin
            read_ptr_q <= read_ptr_next;
         end
      end
   end

   ////////////////////////////////////////
   // Output mux
   ////////////////////////////////////////

   // Select the slot under the read pointer
   // Slot 0 is the fallback when no other bit is set
   always_comb begin
      data_o = data_async_i[0];
      for (int i = 1; i < dc_slice_pkg::BUFFER_DEPTH; i++) begin
         if (read_ptr_q[i]) begin
            data_o = data_async_i[i];
         end
      end
   end

   // Pointer leaves the domain straight from the flops
   assign read_pointer_o = read_ptr_q;

endmodule

// File: src/dc_slice.sv
`timescale 1ns/1ps

module dc_slice (
   // Master domain
   input  logic                              push_clk,
   input  logic                              push_rst_n,
   input  logic                              data_req_i,
   input  logic [dc_slice_pkg::ADDR_WIDTH-1:0] data_add_i,
   input  logic                              data_wen_i,
   input  logic [dc_slice_pkg::DATA_WIDTH-1:0] data_wdata_i,
   input  logic [dc_slice_pkg::BE_WIDTH-1:0]   data_be_i,
   input  logic [dc_slice_pkg::ID_WIDTH-1:0]   data_id_i,
   output logic                              data_gnt_o,
   output logic                              data_r_valid_o,
   output logic [dc_slice_pkg::DATA_WIDTH-1:0] data_r_rdata_o,
   output logic [dc_slice_pkg::ID_WIDTH-1:0]   data_r_id_o,
   // Bank domain
   input  logic                              pop_clk,
   input  logic                              pop_rst_n,
   output logic                              data_req_o,
   output logic [dc_slice_pkg::ADDR_WIDTH-1:0] data_add_o,
   output logic                              data_wen_o,
   output logic [dc_slice_pkg::DATA_WIDTH-1:0] data_wdata_o,
   output logic [dc_slice_pkg::BE_WIDTH-1:0]   data_be_o,
   output logic [dc_slice_pkg::ID_WIDTH-1:0]   data_id_o,
   input  logic                              data_gnt_i,
   input  logic                              data_r_valid_i,
   input  logic [dc_slice_pkg::DATA_WIDTH-1:0] data_r_rdata_i,
   input  logic [dc_slice_pkg::ID_WIDTH-1:0]   data_r_id_i
);

   // Request channel
   dc_slice_pkg::dc_req_t                 req_push_data;
   dc_slice_pkg::dc_req_t                 req_pop_data;
   dc_slice_pkg::dc_req_t                 req_async [dc_slice_pkg::BUFFER_DEPTH];
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] req_write_token;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] req_read_pointer;
   // Response channel
   dc_slice_pkg::dc_resp_t                resp_push_data;
   dc_slice_pkg::dc_resp_t                resp_pop_data;
   dc_slice_pkg::dc_resp_t                resp_async [dc_slice_pkg::BUFFER_DEPTH];
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] resp_write_token;
   logic [dc_slice_pkg::BUFFER_DEPTH-1:0] resp_read_pointer;

   ////////////////////////////////////////
   // Request path push to pop
   ////////////////////////////////////////

   assign req_push_data.addr  = data_add_i;
   assign req_push_data.wen   = data_wen_i;
   assign req_push_data.wdata = data_wdata_i;
   assign req_push_data.be    = data_be_i;
   assign req_push_data.id    = data_id_i;

   // Grant is simply room in the ring
   dc_token_fifo_din #(.payload_t(dc_slice_pkg::dc_req_t)) i_req_din (
      .clk_i(push_clk), .rst_ni(push_rst_n), .data_i(req_push_data), .valid_i(data_req_i),
      .ready_o(data_gnt_o), .write_token_o(req_write_token),
      .read_pointer_i(req_read_pointer), .data_async_o(req_async)
   );

   // Bank grant pops the ring
   dc_token_fifo_dout #(.payload_t(dc_slice_pkg::dc_req_t)) i_req_dout (
      .clk_i(pop_clk), .rst_ni(pop_rst_n), .data_o(req_pop_data), .valid_o(data_req_o),
      .ready_i(data_gnt_i), .write_token_i(req_write_token),
      .read_pointer_o(req_read_pointer), .data_async_i(req_async)
   );

   assign data_add_o   = req_pop_data.addr;
   assign data_wen_o   = req_pop_data.wen;
   assign data_wdata_o = req_pop_data.wdata;
   assign data_be_o    = req_pop_data.be;
   assign data_id_o    = req_pop_data.id;

   ////////////////////////////////////////
   // Response path pop to push
   ////////////////////////////////////////

   assign resp_push_data.rdata = data_r_rdata_i;
   assign resp_push_data.id    = data_r_id_i;

   // No back-pressure toward the bank
   dc_token_fifo_din #(.payload_t(dc_slice_pkg::dc_resp_t)) i_resp_din (
      .clk_i(pop_clk), .rst_ni(pop_rst_n), .data_i(resp_push_data), .valid_i(data_r_valid_i),
      .ready_o(), .write_token_o(resp_write_token),
      .read_pointer_i(resp_read_pointer), .data_async_o(resp_async)
   );

   // Master always takes the response so every valid cycle pops one entry
   dc_token_fifo_dout #(.payload_t(dc_slice_pkg::dc_resp_t)) i_resp_dout (
      .clk_i(push_clk), .rst_ni(push_rst_n), .data_o(resp_pop_data),
      .valid_o(data_r_valid_o), .ready_i(1'b1), .write_token_i(resp_write_token),
      .read_pointer_o(resp_read_pointer), .data_async_i(resp_async)
   );

   assign data_r_rdata_o = resp_pop_data.rdata;
   assign data_r_id_o    = resp_pop_data.id;

endmodule

// File: src/tcdm_bank.sv
`timescale 1ns/1ps

module tcdm_bank (
   input  logic                                pop_clk,
   input  logic                                pop_rst_n,
   input  logic                                req_i,
   input  logic [dc_slice_pkg::ADDR_WIDTH-1:0] add_i,
   input  logic                                wen_i,
   input  logic [dc_slice_pkg::DATA_WIDTH-1:0] wdata_i,
   input  logic [dc_slice_pkg::BE_WIDTH-1:0]   be_i,
   input  logic [dc_slice_pkg::ID_WIDTH-1:0]   id_i,
   output logic                                gnt_o,
   output logic                                r_valid_o,
   output logic [dc_slice_pkg::DATA_WIDTH-1:0] r_rdata_o,
   output logic [dc_slice_pkg::ID_WIDTH-1:0]   r_id_o
);

   // Word array
   logic [dc_slice_pkg::DATA_WIDTH-1:0] mem_q [dc_slice_pkg::BANK_WORDS];
   logic [dc_slice_pkg::BANK_AW-1:0]    word_idx;

   // Byte address to word index
   assign word_idx = add_i[dc_slice_pkg::BANK_AW+1:2];

   // Single port with no conflicts
   assign gnt_o = 1'b1;

   ////////////////////////////////////////
   // Byte-enable write
   ////////////////////////////////////////

   always_ff @(posedge pop_clk) begin
      // wen low means write
      if (req_i && !wen_i) begin
         for (int b = 0; b < dc_slice_pkg::BE_WIDTH; b++) begin
            if (be_i[b]) begin
               mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // Response one cycle after the request
   // Writes answer with zero data
   always_ff @(posedge pop_clk or negedge pop_rst_n) begin
      if (!pop_rst_n) begin
         r_valid_o <= 1'b0;
         r_rdata_o <= '0;
         r_id_o    <= '0;
      end else begin
         r_valid_o <= req_i;
         if (req_i) begin
            r_rdata_o <= wen_i ? mem_q[word_idx] : '0;
            r_id_o    <= id_i;
         end
      end
   end

endmodule

// File: src/dc_mem_top.sv
`timescale 1ns/1ps

module dc_mem_top (
   input  logic                                push_clk,
   input  logic                                push_rst_n,
   input  logic                                pop_clk,
   input  logic                                pop_rst_n,
   // Master request
   input  logic                                data_req_i,
   input  logic [dc_slice_pkg::ADDR_WIDTH-1:0] data_add_i,
   input  logic                                data_wen_i,
   input  logic [dc_slice_pkg::DATA_WIDTH-1:0] data_wdata_i,
   input  logic [dc_slice_pkg::BE_WIDTH-1:0]   data_be_i,
   input  logic [dc_slice_pkg::ID_WIDTH-1:0]   data_id_i,
   output logic                                data_gnt_o,
   // Master response
   output logic                                data_r_valid_o,
   output logic [dc_slice_pkg::DATA_WIDTH-1:0] data_r_rdata_o,
   output logic [dc_slice_pkg::ID_WIDTH-1:0]   data_r_id_o
);

   // Bank-side request
   logic                                bank_req;
   logic [dc_slice_pkg::ADDR_WIDTH-1:0] bank_add;
   logic                                bank_wen;
   logic [dc_slice_pkg::DATA_WIDTH-1:0] bank_wdata;
   logic [dc_slice_pkg::BE_WIDTH-1:0]   bank_be;
   logic [dc_slice_pkg::ID_WIDTH-1:0]   bank_id;
   logic                                bank_gnt;
   // Bank-side response
   logic                                bank_r_valid;
   logic [dc_slice_pkg::DATA_WIDTH-1:0] bank_r_rdata;
   logic [dc_slice_pkg::ID_WIDTH-1:0]   bank_r_id;

   dc_slice i_dc_slice (
      .push_clk, .push_rst_n, .data_req_i, .data_add_i, .data_wen_i, .data_wdata_i,
      .data_be_i, .data_id_i, .data_gnt_o, .data_r_valid_o, .data_r_rdata_o, .data_r_id_o,
      .pop_clk, .pop_rst_n, .data_req_o(bank_req), .data_add_o(bank_add),
      .data_wen_o(bank_wen), .data_wdata_o(bank_wdata), .data_be_o(bank_be),
      .data_id_o(bank_id), .data_gnt_i(bank_gnt), .data_r_valid_i(bank_r_valid),
      .data_r_rdata_i(bank_r_rdata), .data_r_id_i(bank_r_id)
   );

   // Memory lives entirely in the pop domain
   tcdm_bank i_tcdm_bank (
      .pop_clk, .pop_rst_n, .req_i(bank_req), .add_i(bank_add), .wen_i(bank_wen),
      .wdata_i(bank_wdata), .be_i(bank_be), .id_i(bank_id), .gnt_o(bank_gnt),
      .r_valid_o(bank_r_valid), .r_rdata_o(bank_r_rdata), .r_id_o(bank_r_id)
   );

endmodule

// File: tb/dc_slice_sva.sv
`timescale 1ns/1ps

module dc_slice_sva (
   input logic                                  push_clk,
   input logic                                  push_rst_n,
   input logic                                  pop_clk,
   input logic                                  pop_rst_n,
   input logic                                  data_r_valid_i,
   input logic                                  resp_din_ready,
   input logic                                  data_r_valid_o,
   input logic [dc_slice_pkg::BUFFER_DEPTH-1:0] req_write_token,
   input logic [dc_slice_pkg::BUFFER_DEPTH-1:0] req_read_pointer,
   input logic [dc_slice_pkg::BUFFER_DEPTH-1:0] resp_write_token,
   input logic [dc_slice_pkg::BUFFER_DEPTH-1:0] resp_read_pointer
);

   // Bank response must always find room
   resp_no_overflow: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      data_r_valid_i |-> resp_din_ready)
      else $error("Response FIFO written while full");

   ////////////////////////////////////////
   // One-hot ring state
   ////////////////////////////////////////

   req_wtok_onehot: assert property (@(posedge push_clk) disable iff (!push_rst_n)
      $onehot(req_write_token))
      else $error("Request write token not one-hot");
   req_rptr_onehot: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      $onehot(req_read_pointer))
      else $error("Request read pointer not one-hot");
   resp_wtok_onehot: assert property (@(posedge pop_clk) disable iff (!pop_rst_n)
      $onehot(resp_write_token))
      else $error("Response write token not one-hot");
   resp_rptr_onehot: assert property (@(posedge push_clk) disable iff (!push_rst_n)
      $onehot(resp_read_pointer))
      else $error("Response read pointer not one-hot");

   // Valid only with a real entry in the ring
   resp_valid_not_empty: assert property (@(posedge push_clk) disable iff (!push_rst_n)
      data_r_valid_o |-> (resp_write_token != resp_read_pointer))
      else $error("data_r_valid_o raised while the response FIFO is empty");

endmodule

bind dc_slice dc_slice_sva i_dc_slice_sva (
   .push_clk, .push_rst_n, .pop_clk, .pop_rst_n, .data_r_valid_i,
   .resp_din_ready(i_resp_din.ready_o), .data_r_valid_o, .req_write_token,
   .req_read_pointer, .resp_write_token, .resp_read_pointer
);

// File: tb/tb_dc_mem_top.sv
`timescale 1ns/1ps

module tb_dc_mem_top;

   // Wait limits in push_clk cycles
   localparam int GNT_TIMEOUT   = 200;
   localparam int DRAIN_TIMEOUT = 2000;

   logic        push_clk;
   logic        pop_clk;
   logic        push_rst_n;
   logic        pop_rst_n;
   logic        data_req_i;
   logic [31:0] data_add_i;
   logic        data_wen_i;
   logic [31:0] data_wdata_i;
   logic [3:0]  data_be_i;
   logic [3:0]  data_id_i;
   logic        data_gnt_o;
   logic        data_r_valid_o;
   logic [31:0] data_r_rdata_o;
   logic [3:0]  data_r_id_o;

   integer      seed;
   // Reference copy of the bank contents
   logic [31:0] model_mem [dc_slice_pkg::BANK_WORDS];
   // Expected responses with rdata above ID
   logic [35:0] expected_q [$];
   int          stall_cycles;

   dc_mem_top i_dc_mem_top (
      .push_clk, .push_rst_n, .pop_clk, .pop_rst_n, .data_req_i, .data_add_i, .data_wen_i,
      .data_wdata_i, .data_be_i, .data_id_i, .data_gnt_o, .data_r_valid_o, .data_r_rdata_o,
      .data_r_id_o
   );

   ////////////////////////////////////////
   // Clocks
   ////////////////////////////////////////

   initial begin
      push_clk = 1'b0;
      forever #2 push_clk = ~push_clk;
   end

   // Slower bank clock
   initial begin
      pop_clk = 1'b0;
      forever #3 pop_clk = ~pop_clk;
   end

   task automatic stop_on_failure();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
         stop_on_failure();
      end
   endtask

   // Called on a falling edge and returns on the falling edge after the grant
   task automatic issue_request(input logic [5:0] word, input logic wen,
                                input logic [31:0] wdata, input logic [3:0] be,
                                input logic [3:0] id);
      int          waited;
      logic [31:0] exp_rdata;
      data_req_i   = 1'b1;
      data_add_i   = {24'h0, word, 2'b00};
      data_wen_i   = wen;
      data_wdata_i = wdata;
      data_be_i    = be;
      data_id_i    = id;
      waited       = 0;
      // Grant only moves on the rising edge
      while (!data_gnt_o) begin
         stall_cycles++;
         waited++;
         if (waited > GNT_TIMEOUT) begin
            $display("Timeout: data_gnt_o stayed low while a request was pending");
            stop_on_failure();
         end
         @(negedge push_clk);
      end
      // Request is taken on the next rising edge
      // Model follows grant order
      exp_rdata = model_mem[word];
      if (!wen) begin
         for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
               model_mem[word][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         exp_rdata = '0;
      end
      expected_q.push_back({exp_rdata, id});
      @(negedge push_clk);
      data_req_i = 1'b0;
   endtask

   // Random word, direction, lanes and ID, then up to gap_max idle cycles
   task automatic random_request(input int gap_max);
      logic [31:0] pick;
      logic [31:0] wdata;
      int          gap;
      pick  = $random(seed);
      wdata = $random(seed);
      issue_request(pick[5:0], pick[8], wdata, pick[15:12], pick[19:16]);
      gap = pick[27:24] % (gap_max + 1);
      repeat (gap) @(negedge push_clk);
   endtask

   ////////////////////////////////////////
   // Response scoreboard
   ////////////////////////////////////////

   always @(negedge push_clk) begin
      logic [35:0] expected;
      if (push_rst_n && data_r_valid_o) begin
         if (expected_q.size() == 0) begin
            $display("Response on data_r_valid_o with no request outstanding");
            stop_on_failure();
         end else begin
            expected = expected_q.pop_front();
            check_value("data_r_rdata_o", data_r_rdata_o, expected[35:4]);
            check_value("data_r_id_o", {28'h0, data_r_id_o}, {28'h0, expected[3:0]});
         end
      end
   end

   initial begin
      logic [31:0] pick;
      logic [31:0] wdata;
      int          stalls_before;
      int          waited;
      seed          = 57104;
      stall_cycles  = 0;
      push_rst_n    = 1'b0;
      pop_rst_n     = 1'b0;
      data_req_i    = 1'b0;
      data_add_i    = '0;
      data_wen_i    = 1'b0;
      data_wdata_i  = '0;
      data_be_i     = '0;
      data_id_i     = '0;
      // Outputs idle and grant open during reset
      repeat (4) begin
         @(negedge push_clk);
         check_value("data_gnt_o", {31'h0, data_gnt_o}, 32'd1);
         check_value("data_r_valid_o", {31'h0, data_r_valid_o}, 32'd0);
      end
      push_rst_n = 1'b1;
      pop_rst_n  = 1'b1;
      @(negedge push_clk);
      check_value("data_gnt_o", {31'h0, data_gnt_o}, 32'd1);
      check_value("data_r_valid_o", {31'h0, data_r_valid_o}, 32'd0);
      // Known contents in every word
      for (int w = 0; w < dc_slice_pkg::BANK_WORDS; w++) begin
         pick  = $random(seed);
         wdata = $random(seed);
         issue_request(w[5:0], 1'b0, wdata, 4'hf, pick[3:0]);
      end
      // Partial write then read back of the merged word
      for (int k = 0; k < 16; k++) begin
         pick  = $random(seed);
         wdata = $random(seed);
         issue_request(pick[5:0], 1'b0, wdata, pick[15:12], pick[19:16]);
         issue_request(pick[5:0], 1'b1, ~wdata, 4'h0, pick[23:20]);
      end
      // Back-to-back burst must fill the request ring
      stalls_before = stall_cycles;
      for (int k = 0; k < 48; k++) begin
         random_request(0);
      end
      check_value("data_gnt_o low cycles in burst",
                  (stall_cycles > stalls_before) ? 32'd1 : 32'd0, 32'd1);
      for (int k = 0; k < 400; k++) begin
         random_request(3);
      end
      // Drain what is still in flight
      waited = 0;
      while (expected_q.size() != 0) begin
         waited++;
         if (waited > DRAIN_TIMEOUT) begin
            $display("Timeout: responses still outstanding after the drain window");
            stop_on_failure();
         end
         @(negedge push_clk);
      end
      // Quiet window where any late extra response hits the scoreboard
      repeat (40) @(negedge push_clk);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: sim.f
src/dc_slice_pkg.sv
src/dc_token_fifo_din.sv
src/dc_token_fifo_dout.sv
src/dc_slice.sv
src/tcdm_bank.sv
src/dc_mem_top.sv
tb/dc_slice_sva.sv
tb/tb_dc_mem_top.sv

// File: Bender.yml
package:
  name: dc_mem_slice

sources:
  # Design sources in compile order
  - files:
      - src/dc_slice_pkg.sv
      - src/dc_token_fifo_din.sv
      - src/dc_token_fifo_dout.sv
      - src/dc_slice.sv
      - src/tcdm_bank.sv
      - src/dc_mem_top.sv

  # Simulation only
  - target: test
    files:
      - tb/dc_slice_sva.sv
      - tb/tb_dc_mem_top.sv
